// ==== verilog/exu_cfg_pkg.sv ====
package exu_cfg_pkg;

  // Data and PC width of the execution stage
  localparam int xlen_dflt = 32;

  // Integer register file index
  localparam int rfidx_w = 5;

  typedef logic [rfidx_w-1:0] rfidx_t;

endpackage

// ==== verilog/exu_decinfo_pkg.sv ====
package exu_decinfo_pkg;

  // Decode group, picks the compute unit
  typedef enum logic {
    grp_alu = 1'b0,
    grp_bjp = 1'b1
  } grp_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_xor, alu_sll,
    alu_srl, alu_sra, alu_or, alu_and,
    alu_slt, alu_sltu, alu_lui,
    alu_ecall, alu_ebreak, alu_wfi  // Environment ops, no result
  } alu_op_e;

  // Conditional branches first, then jumps, then the special ops
  typedef enum logic [3:0] {
    bjp_beq, bjp_bne, bjp_blt, bjp_bge,
    bjp_bltu, bjp_bgeu,
    bjp_jal, bjp_jalr,
    bjp_mret, bjp_dret, bjp_fencei
  } bjp_op_e;

  // Functions of the shared datapath
  typedef enum logic [4:0] {
    dp_add, dp_sub, dp_xor, dp_sll,
    dp_srl, dp_sra, dp_or, dp_and,
    dp_slt, dp_sltu, dp_lui,
    dp_cmp_eq, dp_cmp_ne, dp_cmp_lt,
    dp_cmp_ge, dp_cmp_ltu, dp_cmp_geu
  } dpath_op_e;

  typedef struct packed {
    grp_e    grp;
    logic    rv32;     // Low for a compressed instruction
    logic    op1_pc;   // First operand is the PC
    logic    op2_imm;  // Second operand is the immediate
    logic    bprdt;    // Branch predicted taken
    alu_op_e alu_op;
    bjp_op_e bjp_op;
  } dec_info_t;

endpackage

// ==== verilog/exu_unit_if.sv ====
`timescale 1ns/1ps

interface exu_unit_if
  import exu_cfg_pkg::*;
  import exu_decinfo_pkg::*;
#(
  parameter int xlen = xlen_dflt
) ();

  logic            sel;    // Unit owns the current instruction
  logic [xlen-1:0] rs1;
  logic [xlen-1:0] rs2;
  logic [xlen-1:0] imm;
  logic [xlen-1:0] pc;
  dec_info_t       info;
  logic            rdwen;

  // Unit result
  logic [xlen-1:0] wdat;
  logic            err;

  modport issue (
    output sel, rs1, rs2, imm, pc, info, rdwen,
    input  wdat, err
  );

  modport unit (
    input  sel, rs1, rs2, imm, pc, info, rdwen,
    output wdat, err
  );

endinterface

// ==== verilog/alu_dpath_if.sv ====
`timescale 1ns/1ps

interface alu_dpath_if
  import exu_cfg_pkg::*;
  import exu_decinfo_pkg::*;
#(
  parameter int xlen = xlen_dflt
) ();

  logic            req;
  dpath_op_e       op;
  logic [xlen-1:0] op1;
  logic [xlen-1:0] op2;
  logic [xlen-1:0] res;
  logic            cmp_res;  // Outcome of a compare op

  modport unit  (output req, op, op1, op2, input  res, cmp_res);
  modport dpath (input  req, op, op1, op2, output res, cmp_res);

endinterface

// ==== verilog/exu_alu_issue.sv ====
`timescale 1ns/1ps

module exu_alu_issue import exu_cfg_pkg::*; import exu_decinfo_pkg::*; #(
  parameter int xlen = xlen_dflt
) (
  input  logic            i_valid,
  output logic            o_ready,
  input  logic [xlen-1:0] i_rs1,
  input  logic [xlen-1:0] i_rs2,
  input  logic [xlen-1:0] i_imm,
  input  logic [xlen-1:0] i_pc,
  input  dec_info_t       i_info,
  input  rfidx_t          i_rdidx,
  input  logic            i_rdwen,
  input  logic            i_ilegl,
  input  logic            i_buserr,
  input  logic            i_misalgn,
  output logic            o_cmt_valid,
  input  logic            i_cmt_ready,
  output logic [xlen-1:0] o_cmt_pc,
  output logic            o_cmt_rv32,
  output logic            o_cmt_bjp,
  output logic            o_cmt_bjp_prdt,
  output logic            o_cmt_bjp_rslv,
  output logic            o_cmt_mret,
  output logic            o_cmt_dret,
  output logic            o_cmt_fencei,
  output logic            o_cmt_ecall,
  output logic            o_cmt_ebreak,
  output logic            o_cmt_wfi,
  output logic            o_cmt_ifu_ilegl,
  output logic            o_cmt_ifu_buserr,
  output logic            o_cmt_ifu_misalgn,
  output logic            o_wbck_valid,
  input  logic            i_wbck_ready,
  output logic [xlen-1:0] o_wbck_wdat,
  output rfidx_t          o_wbck_rdidx,

  exu_unit_if.issue       rglr_if,
  exu_unit_if.issue       bjp_if,
  input  logic            i_ecall,
  input  logic            i_ebreak,
  input  logic            i_wfi,
  input  logic            i_bjp,
  input  logic            i_prdt,
  input  logic            i_rslv,
  input  logic            i_mret,
  input  logic            i_dret,
  input  logic            i_fencei
);

  logic            ifu_excp;
  logic            sel_rglr;
  logic            sel_bjp;
  logic            wbck_err;
  logic            need_wbck;

  //////////////////////////////////////////////////
  // Dispatch by group
  assign ifu_excp = i_ilegl | i_buserr | i_misalgn;  // Overrides the group
  assign sel_rglr = ~ifu_excp & (i_info.grp == grp_alu);
  assign sel_bjp  = ~ifu_excp & (i_info.grp == grp_bjp);

  // Unselected unit sees all-zero operands
  assign rglr_if.sel   = sel_rglr;
  assign rglr_if.rs1   = sel_rglr ? i_rs1 : '0;
  assign rglr_if.rs2   = sel_rglr ? i_rs2 : '0;
  assign rglr_if.imm   = sel_rglr ? i_imm : '0;
  assign rglr_if.pc    = sel_rglr ? i_pc  : '0;
  assign rglr_if.info  = sel_rglr ? i_info : dec_info_t'('0);
  assign rglr_if.rdwen = sel_rglr & i_rdwen;

  assign bjp_if.sel    = sel_bjp;
  assign bjp_if.rs1    = sel_bjp ? i_rs1 : '0;
  assign bjp_if.rs2    = sel_bjp ? i_rs2 : '0;
  assign bjp_if.imm    = sel_bjp ? i_imm : '0;
  assign bjp_if.pc     = sel_bjp ? i_pc  : '0;
  assign bjp_if.info   = sel_bjp ? i_info : dec_info_t'('0);
  assign bjp_if.rdwen  = sel_bjp & i_rdwen;

  //////////////////////////////////////////////////
  // Result merge

  // Exception path writes zero, as no unit is selected
  assign o_wbck_wdat = ({xlen{sel_rglr}} & rglr_if.wdat)
                     | ({xlen{sel_bjp}}  & bjp_if.wdat);
  assign wbck_err    = (sel_rglr & rglr_if.err)
                     | (sel_bjp  & bjp_if.err)
                     | ifu_excp;  // Fetch exception always fails write-back

  // Both channels move together or not at all
  assign need_wbck    = i_rdwen & ~wbck_err;
  assign o_ready      = i_cmt_ready & (~need_wbck | i_wbck_ready);
  assign o_cmt_valid  = i_valid & (~need_wbck | i_wbck_ready);
  assign o_wbck_valid = need_wbck & i_valid & i_cmt_ready;
  assign o_wbck_rdidx = i_rdidx;

  assign o_cmt_pc          = i_pc;
  assign o_cmt_rv32        = i_info.rv32;
  assign o_cmt_bjp         = sel_bjp & i_bjp;
  assign o_cmt_bjp_prdt    = sel_bjp & i_prdt;
  assign o_cmt_bjp_rslv    = sel_bjp & i_rslv;
  assign o_cmt_mret        = sel_bjp & i_mret;
  assign o_cmt_dret        = sel_bjp & i_dret;
  assign o_cmt_fencei      = sel_bjp & i_fencei;
  assign o_cmt_ecall       = sel_rglr & i_ecall;
  assign o_cmt_ebreak      = sel_rglr & i_ebreak;
  assign o_cmt_wfi         = sel_rglr & i_wfi;
  assign o_cmt_ifu_ilegl   = i_ilegl;
  assign o_cmt_ifu_buserr  = i_buserr;
  assign o_cmt_ifu_misalgn = i_misalgn;

endmodule

// ==== verilog/exu_alu_rglr.sv ====
`timescale 1ns/1ps

module exu_alu_rglr import exu_cfg_pkg::*; import exu_decinfo_pkg::*; #(
  parameter int xlen = xlen_dflt
) (
  exu_unit_if.unit   u_if,
  alu_dpath_if.unit  dp_if,
  output logic       o_ecall,
  output logic       o_ebreak,
  output logic       o_wfi
);

  logic env_op;

  assign o_ecall  = (u_if.info.alu_op == alu_ecall);
  assign o_ebreak = (u_if.info.alu_op == alu_ebreak);
  assign o_wfi    = (u_if.info.alu_op == alu_wfi);
  assign env_op   = o_ecall | o_ebreak | o_wfi;

  // Datapath only needed when the result is written back
  assign dp_if.req = u_if.sel & u_if.rdwen;
  assign dp_if.op1 = u_if.info.op1_pc  ? u_if.pc  : u_if.rs1;
  assign dp_if.op2 = u_if.info.op2_imm ? u_if.imm : u_if.rs2;

  always_comb begin
    case (u_if.info.alu_op)
      alu_add:  dp_if.op = dp_add;
      alu_sub:  dp_if.op = dp_sub;
      alu_xor:  dp_if.op = dp_xor;
      alu_sll:  dp_if.op = dp_sll;
      alu_srl:  dp_if.op = dp_srl;
      alu_sra:  dp_if.op = dp_sra;
      alu_or:   dp_if.op = dp_or;
      alu_and:  dp_if.op = dp_and;
      alu_slt:  dp_if.op = dp_slt;
      alu_sltu: dp_if.op = dp_sltu;
      alu_lui:  dp_if.op = dp_lui;
      default:  dp_if.op = dp_add;  // Env ops, result unused
    endcase
  end

  // Env ops trap at commit and write nothing
  assign u_if.wdat = dp_if.res & {xlen{~env_op}};
  assign u_if.err  = env_op;

endmodule

// ==== verilog/exu_alu_bjp.sv ====
`timescale 1ns/1ps

module exu_alu_bjp import exu_cfg_pkg::*; import exu_decinfo_pkg::*; #(
  parameter int xlen = xlen_dflt
) (
  exu_unit_if.unit   u_if,
  alu_dpath_if.unit  dp_if,
  output logic       o_bjp,
  output logic       o_prdt,
  output logic       o_rslv,
  output logic       o_mret,
  output logic       o_dret,
  output logic       o_fencei
);

  logic jump;
  logic branch;

  assign jump   = (u_if.info.bjp_op == bjp_jal) | (u_if.info.bjp_op == bjp_jalr);
  assign branch = (u_if.info.bjp_op <= bjp_bgeu);

  // Jumps add the link offset to the PC, branches compare rs1 and rs2
  assign dp_if.req = u_if.sel;
  assign dp_if.op1 = jump ? u_if.pc : u_if.rs1;
  assign dp_if.op2 = jump ? {{(xlen-3){1'b0}}, u_if.info.rv32, ~u_if.info.rv32, 1'b0}
                          : u_if.rs2;  // 4, or 2 when compressed

  always_comb begin
    case (u_if.info.bjp_op)
      bjp_beq:  dp_if.op = dp_cmp_eq;
      bjp_bne:  dp_if.op = dp_cmp_ne;
      bjp_blt:  dp_if.op = dp_cmp_lt;
      bjp_bge:  dp_if.op = dp_cmp_ge;
      bjp_bltu: dp_if.op = dp_cmp_ltu;
      bjp_bgeu: dp_if.op = dp_cmp_geu;
      default:  dp_if.op = dp_add;
    endcase
  end

  assign u_if.wdat = dp_if.res;  // Link address on jumps
  assign u_if.err  = 1'b0;

  assign o_bjp    = jump | branch;
  assign o_prdt   = u_if.info.bprdt;
  assign o_rslv   = jump | (branch & dp_if.cmp_res);
  assign o_mret   = (u_if.info.bjp_op == bjp_mret);
  assign o_dret   = (u_if.info.bjp_op == bjp_dret);
  assign o_fencei = (u_if.info.bjp_op == bjp_fencei);

endmodule

// ==== verilog/exu_alu_dpath.sv ====
`timescale 1ns/1ps

module exu_alu_dpath import exu_cfg_pkg::*; import exu_decinfo_pkg::*; #(
  parameter int xlen = xlen_dflt
) (
  alu_dpath_if.dpath rglr_dp,
  alu_dpath_if.dpath bjp_dp
);

  localparam int shw = $clog2(xlen);

  dpath_op_e       op;
  logic [xlen-1:0] op1;
  logic [xlen-1:0] op2;
  logic            sub_en;
  logic            sgn_en;
  logic [xlen:0]   add_a;
  logic [xlen:0]   add_b;
  logic [xlen:0]   add_res;
  logic            lt;
  logic            eq;
  logic [xlen-1:0] op1_rev;
  logic [xlen-1:0] shin;
  logic [xlen-1:0] shr_res;
  logic [xlen-1:0] sll_res;
  logic [xlen-1:0] res;
  logic            cmp_res;

  // Regular ALU wins when both sides request
  assign op  = rglr_dp.req ? rglr_dp.op  : bjp_dp.op;
  assign op1 = rglr_dp.req ? rglr_dp.op1 : bjp_dp.op1;
  assign op2 = rglr_dp.req ? rglr_dp.op2 : bjp_dp.op2;

  //////////////////////////////////////////////////
  // Shared adder, one extra bit for the compare
  assign sub_en = (op == dp_sub) | (op == dp_slt) | (op == dp_sltu) | (op >= dp_cmp_eq);
  assign sgn_en = (op == dp_slt) | (op == dp_cmp_lt) | (op == dp_cmp_ge);
  assign add_a  = {sgn_en & op1[xlen-1], op1};
  assign add_b  = {sgn_en & op2[xlen-1], op2};
  assign add_res = add_a + (sub_en ? ~add_b : add_b) + {{xlen{1'b0}}, sub_en};

  assign lt = add_res[xlen];          // Sign of the difference
  assign eq = ~|add_res[xlen-1:0];

  //////////////////////////////////////////////////
  // Right shifter, left shift by bit reversal
  for (genvar i = 0; i < xlen; i++) begin : g_rev
    assign op1_rev[i] = op1[xlen-1-i];
    assign sll_res[i] = shr_res[xlen-1-i];
  end

  assign shin    = (op == dp_sll) ? op1_rev : op1;
  assign shr_res = xlen'($signed({(op == dp_sra) & op1[xlen-1], shin}) >>> op2[shw-1:0]);

  always_comb begin
    case (op)
      dp_add, dp_sub:  res = add_res[xlen-1:0];
      dp_xor:          res = op1 ^ op2;
      dp_sll:          res = sll_res;
      dp_srl, dp_sra:  res = shr_res;
      dp_or:           res = op1 | op2;
      dp_and:          res = op1 & op2;
      dp_slt, dp_sltu: res = {{(xlen-1){1'b0}}, lt};
      dp_lui:          res = op2;  // Immediate already shifted by decode
      default:         res = '0;
    endcase
  end

  always_comb begin
    case (op)
      dp_cmp_eq:              cmp_res = eq;
      dp_cmp_ne:              cmp_res = ~eq;
      dp_cmp_lt, dp_cmp_ltu:  cmp_res = lt;
      dp_cmp_ge, dp_cmp_geu:  cmp_res = ~lt;
      default:                cmp_res = 1'b0;
    endcase
  end

  assign rglr_dp.res     = res;
  assign rglr_dp.cmp_res = cmp_res;
  assign bjp_dp.res      = res;
  assign bjp_dp.cmp_res  = cmp_res;

endmodule

// ==== verilog/exu_alu.sv ====
`timescale 1ns/1ps

module exu_alu import exu_cfg_pkg::*; import exu_decinfo_pkg::*; #(
  parameter int xlen = xlen_dflt
) (
  input  logic            i_valid,
  output logic            o_ready,
  input  logic [xlen-1:0] i_rs1,
  input  logic [xlen-1:0] i_rs2,
  input  logic [xlen-1:0] i_imm,
  input  logic [xlen-1:0] i_pc,
  input  dec_info_t       i_info,
  input  rfidx_t          i_rdidx,
  input  logic            i_rdwen,
  input  logic            i_ilegl,
  input  logic            i_buserr,
  input  logic            i_misalgn,

  // Commit channel
  output logic            o_cmt_valid,
  input  logic            i_cmt_ready,
  output logic [xlen-1:0] o_cmt_pc,
  output logic            o_cmt_rv32,
  output logic            o_cmt_bjp,
  output logic            o_cmt_bjp_prdt,
  output logic            o_cmt_bjp_rslv,
  output logic            o_cmt_mret,
  output logic            o_cmt_dret,
  output logic            o_cmt_fencei,
  output logic            o_cmt_ecall,
  output logic            o_cmt_ebreak,
  output logic            o_cmt_wfi,
  output logic            o_cmt_ifu_ilegl,
  output logic            o_cmt_ifu_buserr,
  output logic            o_cmt_ifu_misalgn,

  // Write-back channel
  output logic            o_wbck_valid,
  input  logic            i_wbck_ready,
  output logic [xlen-1:0] o_wbck_wdat,
  output rfidx_t          o_wbck_rdidx
);

  logic rglr_ecall;
  logic rglr_ebreak;
  logic rglr_wfi;
  logic bjp_cmt;
  logic bjp_prdt;
  logic bjp_rslv;
  logic bjp_mret;
  logic bjp_dret;
  logic bjp_fencei;

  exu_unit_if  #(.xlen(xlen)) rglr_uif ();
  exu_unit_if  #(.xlen(xlen)) bjp_uif ();
  alu_dpath_if #(.xlen(xlen)) rglr_dpif ();
  alu_dpath_if #(.xlen(xlen)) bjp_dpif ();

  exu_alu_issue #(.xlen(xlen)) u_exu_alu_issue (
    .*,
    .rglr_if  (rglr_uif),
    .bjp_if   (bjp_uif),
    .i_ecall  (rglr_ecall),
    .i_ebreak (rglr_ebreak),
    .i_wfi    (rglr_wfi),
    .i_bjp    (bjp_cmt),
    .i_prdt   (bjp_prdt),
    .i_rslv   (bjp_rslv),
    .i_mret   (bjp_mret),
    .i_dret   (bjp_dret),
    .i_fencei (bjp_fencei)
  );

  exu_alu_rglr #(.xlen(xlen)) u_exu_alu_rglr (
    .u_if     (rglr_uif),
    .dp_if    (rglr_dpif),
    .o_ecall  (rglr_ecall),
    .o_ebreak (rglr_ebreak),
    .o_wfi    (rglr_wfi)
  );

  exu_alu_bjp #(.xlen(xlen)) u_exu_alu_bjp (
    .u_if     (bjp_uif),
    .dp_if    (bjp_dpif),
    .o_bjp    (bjp_cmt),
    .o_prdt   (bjp_prdt),
    .o_rslv   (bjp_rslv),
    .o_mret   (bjp_mret),
    .o_dret   (bjp_dret),
    .o_fencei (bjp_fencei)
  );

  exu_alu_dpath #(.xlen(xlen)) u_exu_alu_dpath (
    .rglr_dp (rglr_dpif),
    .bjp_dp  (bjp_dpif)
  );

endmodule

// ==== include/tb_exu_alu_ref.svh ====
`ifndef TB_EXU_ALU_REF_SVH
`define TB_EXU_ALU_REF_SVH

// Included in the testbench module body, after its package imports

typedef struct packed {
  logic                 ready;
  logic                 cmt_valid;
  logic                 wbck_valid;
  logic                 chk_wdat;  // Write data is defined only on write-back
  logic [xlen_dflt-1:0] wdat;
  logic                 bjp;
  logic                 prdt;
  logic                 rslv;
  logic                 mret;
  logic                 dret;
  logic                 fencei;
  logic                 ecall;
  logic                 ebreak;
  logic                 wfi;
} exu_exp_t;

function automatic exu_exp_t exu_ref_predict(
  input logic                 valid,
  input logic [xlen_dflt-1:0] rs1,
  input logic [xlen_dflt-1:0] rs2,
  input logic [xlen_dflt-1:0] imm,
  input logic [xlen_dflt-1:0] pc,
  input dec_info_t            info,
  input logic                 rdwen,
  input logic                 excp,      // Any fetch exception
  input logic                 cmt_ready,
  input logic                 wbck_ready
);
  exu_exp_t                     e;
  logic [xlen_dflt-1:0]         a;
  logic [xlen_dflt-1:0]         b;
  logic [$clog2(xlen_dflt)-1:0] sh;
  logic                         err;
  logic                         need_wbck;
  e   = '0;
  a   = info.op1_pc  ? pc  : rs1;
  b   = info.op2_imm ? imm : rs2;
  sh  = b[$clog2(xlen_dflt)-1:0];
  err = excp;
  if (!excp && info.grp == grp_alu) begin
    case (info.alu_op)
      alu_add:  e.wdat = a + b;
      alu_sub:  e.wdat = a - b;
      alu_xor:  e.wdat = a ^ b;
      alu_sll:  e.wdat = a << sh;
      alu_srl:  e.wdat = a >> sh;
      alu_sra:  e.wdat = $signed(a) >>> sh;
      alu_or:   e.wdat = a | b;
      alu_and:  e.wdat = a & b;
      alu_slt:  e.wdat = xlen_dflt'($signed(a) < $signed(b));
      alu_sltu: e.wdat = xlen_dflt'(a < b);
      alu_lui:  e.wdat = b;
      default: begin
        err      = 1'b1;
        e.ecall  = (info.alu_op == alu_ecall);
        e.ebreak = (info.alu_op == alu_ebreak);
        e.wfi    = (info.alu_op == alu_wfi);
      end
    endcase
  end else if (!excp) begin
    case (info.bjp_op)
      bjp_beq:  e.rslv = (rs1 == rs2);
      bjp_bne:  e.rslv = (rs1 != rs2);
      bjp_blt:  e.rslv = ($signed(rs1) < $signed(rs2));
      bjp_bge:  e.rslv = ($signed(rs1) >= $signed(rs2));
      bjp_bltu: e.rslv = (rs1 < rs2);
      bjp_bgeu: e.rslv = (rs1 >= rs2);
      bjp_jal, bjp_jalr: begin
        e.rslv = 1'b1;
        e.wdat = pc + (info.rv32 ? 4 : 2);
      end
      default: e.rslv = 1'b0;
    endcase
    e.bjp    = (info.bjp_op <= bjp_jalr);
    e.prdt   = info.bprdt;
    e.mret   = (info.bjp_op == bjp_mret);
    e.dret   = (info.bjp_op == bjp_dret);
    e.fencei = (info.bjp_op == bjp_fencei);
  end
  need_wbck    = rdwen & ~err;
  e.chk_wdat   = need_wbck;
  e.ready      = cmt_ready & (~need_wbck | wbck_ready);
  e.cmt_valid  = valid & (~need_wbck | wbck_ready);
  e.wbck_valid = valid & need_wbck & cmt_ready;
  return e;
endfunction

`endif

// ==== testbench/tb_exu_alu.sv ====
`timescale 1ns/1ps

module tb_exu_alu import exu_cfg_pkg::*; import exu_decinfo_pkg::*; ();

  localparam int xlen        = xlen_dflt;
  localparam int ready_limit = 20;  // Cycles allowed for o_ready

  `include "tb_exu_alu_ref.svh"

  logic            clk;
  logic            i_rst;
  logic            i_valid;
  logic            o_ready;
  logic [xlen-1:0] i_rs1;
  logic [xlen-1:0] i_rs2;
  logic [xlen-1:0] i_imm;
  logic [xlen-1:0] i_pc;
  dec_info_t       i_info;
  rfidx_t          i_rdidx;
  logic            i_rdwen;
  logic            i_ilegl;
  logic            i_buserr;
  logic            i_misalgn;
  logic            o_cmt_valid;
  logic            i_cmt_ready;
  logic [xlen-1:0] o_cmt_pc;
  logic            o_cmt_rv32;
  logic            o_cmt_bjp;
  logic            o_cmt_bjp_prdt;
  logic            o_cmt_bjp_rslv;
  logic            o_cmt_mret;
  logic            o_cmt_dret;
  logic            o_cmt_fencei;
  logic            o_cmt_ecall;
  logic            o_cmt_ebreak;
  logic            o_cmt_wfi;
  logic            o_cmt_ifu_ilegl;
  logic            o_cmt_ifu_buserr;
  logic            o_cmt_ifu_misalgn;
  logic            o_wbck_valid;
  logic            i_wbck_ready;
  logic [xlen-1:0] o_wbck_wdat;
  rfidx_t          o_wbck_rdidx;

  integer seed;

  exu_alu #(.xlen(xlen)) exu_alu_i (.*);

  always #20 clk = ~clk;  // 40 ns period

  task automatic check_value(input string name, input logic [xlen-1:0] exp_val,
                             input logic [xlen-1:0] got_val);
    if (got_val !== exp_val) begin
      $display("[FAIL] %0t ns %s expected %h got %h", $time, name, exp_val, got_val);
      $display("Test FAILED");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  //////////////////////////////////////////////////
  // Compare process
  task automatic compare_outputs();
    exu_exp_t e;
    e = exu_ref_predict(i_valid, i_rs1, i_rs2, i_imm, i_pc, i_info, i_rdwen,
                        i_ilegl | i_buserr | i_misalgn, i_cmt_ready, i_wbck_ready);
    check_value("o_ready", e.ready, o_ready);
    check_value("o_cmt_valid", e.cmt_valid, o_cmt_valid);
    check_value("o_wbck_valid", e.wbck_valid, o_wbck_valid);
    if (e.chk_wdat) begin
      check_value("o_wbck_wdat", e.wdat, o_wbck_wdat);
    end
    check_value("o_wbck_rdidx", i_rdidx, o_wbck_rdidx);
    check_value("o_cmt_pc", i_pc, o_cmt_pc);
    check_value("o_cmt_rv32", i_info.rv32, o_cmt_rv32);
    check_value("o_cmt_bjp", e.bjp, o_cmt_bjp);
    check_value("o_cmt_bjp_prdt", e.prdt, o_cmt_bjp_prdt);
    check_value("o_cmt_bjp_rslv", e.rslv, o_cmt_bjp_rslv);
    check_value("o_cmt_mret", e.mret, o_cmt_mret);
    check_value("o_cmt_dret", e.dret, o_cmt_dret);
    check_value("o_cmt_fencei", e.fencei, o_cmt_fencei);
    check_value("o_cmt_ecall", e.ecall, o_cmt_ecall);
    check_value("o_cmt_ebreak", e.ebreak, o_cmt_ebreak);
    check_value("o_cmt_wfi", e.wfi, o_cmt_wfi);
    check_value("o_cmt_ifu_ilegl", i_ilegl, o_cmt_ifu_ilegl);
    check_value("o_cmt_ifu_buserr", i_buserr, o_cmt_ifu_buserr);
    check_value("o_cmt_ifu_misalgn", i_misalgn, o_cmt_ifu_misalgn);
  endtask

  always @(posedge clk) begin
    if (!i_rst) compare_outputs();  // Inputs settled since the falling edge
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  function automatic dec_info_t build_info(input grp_e grp, input logic rv32,
                                           input logic op1_pc, input logic op2_imm,
                                           input logic bprdt, input alu_op_e alu_op,
                                           input bjp_op_e bjp_op);
    dec_info_t info;
    info.grp     = grp;
    info.rv32    = rv32;
    info.op1_pc  = op1_pc;
    info.op2_imm = op2_imm;
    info.bprdt   = bprdt;
    info.alu_op  = alu_op;
    info.bjp_op  = bjp_op;
    return info;
  endfunction

  task automatic issue_instr(input dec_info_t info, input logic rdwen,
                             input logic [2:0] excp, input logic same_ops);
    @(negedge clk);
    i_valid = 1'b1;
    i_rs1   = $random(seed);
    i_rs2   = same_ops ? i_rs1 : $random(seed);  // Hits the equal case of branches
    i_imm   = $random(seed);
    i_pc    = $random(seed);
    i_info  = info;
    i_rdidx = rfidx_t'($random(seed));
    i_rdwen = rdwen;
    {i_misalgn, i_buserr, i_ilegl} = excp;
  endtask

  task automatic set_ready(input logic cmt_rdy, input logic wbck_rdy);
    i_cmt_ready  = cmt_rdy;
    i_wbck_ready = wbck_rdy;
  endtask

  task automatic wait_ready(input int limit);
    int cnt;
    cnt = 0;
    @(posedge clk);
    while (!o_ready) begin
      cnt++;
      if (cnt > limit) begin
        $display("Timeout: o_ready stayed low for %0d cycles", limit);
        $display("Test FAILED");
        $fatal(1, "Handshake timeout");
      end
      @(posedge clk);
    end
  endtask

  task automatic run_instr(input dec_info_t info, input logic rdwen,
                           input logic [2:0] excp, input logic same_ops);
    issue_instr(info, rdwen, excp, same_ops);
    set_ready(1'b1, 1'b1);
    wait_ready(ready_limit);
  endtask

  // Hold one channel off for a few cycles, then release both
  task automatic stall_instr(input dec_info_t info, input logic rdwen,
                             input logic cmt_rdy, input logic wbck_rdy, input int cycles);
    issue_instr(info, rdwen, 3'b000, 1'b0);
    set_ready(cmt_rdy, wbck_rdy);
    repeat (cycles) @(posedge clk);
    @(negedge clk);
    set_ready(1'b1, 1'b1);
    wait_ready(ready_limit);
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    i_valid = 1'b0;
    @(posedge clk);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  initial begin
    int          n;
    logic [31:0] r;
    seed      = 32'h16362678;
    clk       = 1'b0;
    i_rst     = 1'b1;
    i_valid   = 1'b0;
    i_rs1     = '0;
    i_rs2     = '0;
    i_imm     = '0;
    i_pc      = '0;
    i_info    = '0;
    i_rdidx   = '0;
    i_rdwen   = 1'b0;
    i_ilegl   = 1'b0;
    i_buserr  = 1'b0;
    i_misalgn = 1'b0;
    set_ready(1'b1, 1'b1);
    repeat (5) @(posedge clk);
    @(negedge clk);
    i_rst = 1'b0;
    idle_cycle();

    // Regular ALU ops with write-back
    for (int k = 0; k < 200; k++) begin
      r = $random(seed);
      n = $unsigned($random(seed)) % 11;
      run_instr(build_info(grp_alu, r[0], r[1], r[2], 1'b0, alu_op_e'(n), bjp_beq),
                1'b1, 3'b000, 1'b0);
    end
    idle_cycle();

    // Conditional branches
    for (int k = 0; k < 120; k++) begin
      r = $random(seed);
      n = $unsigned($random(seed)) % 6;
      run_instr(build_info(grp_bjp, r[0], 1'b0, 1'b0, r[1], alu_add, bjp_op_e'(n)),
                1'b0, 3'b000, r[3]);
    end
    // Jumps, full size and compressed
    for (int k = 0; k < 8; k++) begin
      run_instr(build_info(grp_bjp, k[0], 1'b0, 1'b0, k[2], alu_add,
                           k[1] ? bjp_jalr : bjp_jal), 1'b1, 3'b000, 1'b0);
    end
    run_instr(build_info(grp_bjp, 1'b1, 1'b0, 1'b0, 1'b0, alu_add, bjp_mret),
              1'b0, 3'b000, 1'b0);
    run_instr(build_info(grp_bjp, 1'b1, 1'b0, 1'b0, 1'b0, alu_add, bjp_dret),
              1'b0, 3'b000, 1'b0);
    run_instr(build_info(grp_bjp, 1'b1, 1'b0, 1'b0, 1'b1, alu_add, bjp_fencei),
              1'b0, 3'b000, 1'b0);
    idle_cycle();

    // Fetch exceptions on either group
    for (int k = 0; k < 30; k++) begin
      r = $random(seed);
      n = $unsigned($random(seed)) % 6;
      run_instr(build_info(grp_e'(r[0]), r[1], r[2], r[3], r[4], alu_op_e'(n),
                           bjp_op_e'(n)), 1'b1, 3'b001 << (k % 3), 1'b0);
    end
    // Environment ops
    for (int k = 0; k < 6; k++) begin
      run_instr(build_info(grp_alu, 1'b1, 1'b0, 1'b0, 1'b0,
                           alu_op_e'(int'(alu_ecall) + (k % 3)), bjp_beq),
                1'b1, 3'b000, 1'b0);
    end

    // No write-back wanted
    for (int k = 0; k < 20; k++) begin
      r = $random(seed);
      n = $unsigned($random(seed)) % 11;
      run_instr(build_info(grp_alu, r[0], r[1], r[2], 1'b0, alu_op_e'(n), bjp_beq),
                1'b0, 3'b000, 1'b0);
    end
    idle_cycle();

    // Back-pressure on each channel
    stall_instr(build_info(grp_alu, 1'b1, 1'b0, 1'b1, 1'b0, alu_add, bjp_beq),
                1'b1, 1'b0, 1'b1, 3);
    stall_instr(build_info(grp_alu, 1'b1, 1'b0, 1'b0, 1'b0, alu_xor, bjp_beq),
                1'b1, 1'b1, 1'b0, 3);
    stall_instr(build_info(grp_bjp, 1'b0, 1'b0, 1'b0, 1'b0, alu_add, bjp_jal),
                1'b1, 1'b1, 1'b0, 2);
    stall_instr(build_info(grp_alu, 1'b1, 1'b0, 1'b0, 1'b0, alu_or, bjp_beq),
                1'b0, 1'b1, 1'b0, 2);  // Passes at once, no write-back
    stall_instr(build_info(grp_bjp, 1'b1, 1'b0, 1'b0, 1'b1, alu_add, bjp_bne),
                1'b0, 1'b0, 1'b0, 4);
    idle_cycle();

    $display("Test OK");
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+include
verilog/exu_cfg_pkg.sv
verilog/exu_decinfo_pkg.sv
verilog/exu_unit_if.sv
verilog/alu_dpath_if.sv
verilog/exu_alu_issue.sv
verilog/exu_alu_rglr.sv
verilog/exu_alu_bjp.sv
verilog/exu_alu_dpath.sv
verilog/exu_alu.sv
testbench/tb_exu_alu.sv

// ==== Bender.yml ====
package:
  name: exu_alu

sources:
  - files:
      - verilog/exu_cfg_pkg.sv
      - verilog/exu_decinfo_pkg.sv
      - verilog/exu_unit_if.sv
      - verilog/alu_dpath_if.sv
      - verilog/exu_alu_issue.sv
      - verilog/exu_alu_rglr.sv
      - verilog/exu_alu_bjp.sv
      - verilog/exu_alu_dpath.sv
      - verilog/exu_alu.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_exu_alu.sv
